// File: include/main_settings.svh
// Board widths, memory map codes and sound-chip register numbers, included by the RTL
`ifndef MAIN_SETTINGS_SVH
`define MAIN_SETTINGS_SVH

// CPU bus widths
`define MAIN_ADDR_W   16
`define MAIN_DATA_W   8

// Memory widths seen from the descrambled address
`define MAIN_RAM_AW   11    // 2 KB work RAM
`define MAIN_ROM_AW   15    // 32 KB program ROM
`define MAIN_VID_AW   13    // Text and background windows

// Region codes on descrambled bits 15:13
`define MAP_RAM       3'b100
`define MAP_TXT       3'b101
`define MAP_BGD       3'b110
`define MAP_SEC       3'b111

// Sound chip
`define PSG_REG_COUNT 16
`define PSG_REG_IOA   14    // Flip and DIP mux select
`define PSG_REG_IOB   15    // DIP switch read
`endif

// File: logic/main_pkg.sv
// Shared types of the main board, imported by every RTL block and the testbench
`default_nettype none
`include "main_settings.svh"

package main_pkg;

    typedef logic [`MAIN_ADDR_W-1:0] addr_t;     // CPU address
    typedef logic [`MAIN_DATA_W-1:0] byte_t;     // Data bus
    typedef logic [`MAIN_ROM_AW-1:0] rom_addr_t;
    typedef logic [`MAIN_RAM_AW-1:0] ram_addr_t;
    typedef logic [`MAIN_VID_AW-1:0] vid_addr_t;

    // One CPU bus cycle, strobes active high
    typedef struct packed {
        logic  mreq;
        logic  iorq;
        logic  rd;
        logic  wr;
        addr_t addr;    // Still scrambled
        byte_t wdata;
    } cpu_bus_t;

    // Decoder output
    typedef struct packed {
        logic       rom;
        logic       ram;
        logic       txt;
        logic       bgd;
        logic       sec;
        logic       io_rd;
        logic       psg_addr_wr;
        logic       psg_data_wr;
        logic       psg_rd;
        logic [1:0] port;   // Input port number
    } chip_sel_t;

    typedef struct packed {
        logic [4:0] joy1;   // Punch, up, down, left, right
        logic [4:0] joy2;
        logic [1:0] start;
        logic       coin;
        logic       service;
        logic       vblank;
    } cabinet_t;

    typedef struct packed {
        logic      valid;
        logic      bgd;     // Set for background, clear for text
        vid_addr_t addr;
        byte_t     data;
    } vid_wr_t;

endpackage

`default_nettype wire

// File: logic/addr_decode.sv
// Address descrambler and chip-select decoder, purely combinational, sits on the CPU bus
`timescale 1ns/1ps
`default_nettype none
`include "main_settings.svh"

module addr_decode import main_pkg::*; (
    input  cpu_bus_t  bus,
    output addr_t     addr,
    output chip_sel_t sel
);

    //////////////////////////////////////////////////////////////////////
    // Address obfuscation, undone by two buffer stages on the board

    assign addr[2:0]   = ~bus.addr[2:0];    // Inverting buffer
    assign addr[3]     = ~bus.addr[4];
    assign addr[4]     = ~bus.addr[5];
    assign addr[5]     = ~bus.addr[9];
    assign addr[6]     = bus.addr[3];       // Plain reorder
    assign addr[7]     = bus.addr[6];
    assign addr[8]     = bus.addr[7];
    assign addr[9]     = bus.addr[8];
    assign addr[15:10] = bus.addr[15:10];   // Untouched

    //////////////////////////////////////////////////////////////////////
    // Chip selects

    always_comb begin
        sel = '0;

        // Memory side only looks at iorq
        // mreq would come too late for the ROM fetch
        if (!bus.iorq) begin
            case (addr[15:13])
                `MAP_RAM: sel.ram = bus.mreq && !addr[11];   // Upper 2 KB open
                `MAP_TXT: sel.txt = bus.mreq;
                `MAP_BGD: sel.bgd = bus.mreq;
                `MAP_SEC: sel.sec = 1'b1;
                default:  sel.rom = 1'b1;                    // 0000-7FFF
            endcase
        end

        // I/O side
        sel.port        = addr[1:0];
        sel.io_rd       = bus.iorq && bus.rd;
        sel.psg_rd      = sel.io_rd && (addr[1:0] == 2'd0);  // Port 0 is the PSG
        sel.psg_addr_wr = bus.iorq && bus.wr && !addr[0];
        sel.psg_data_wr = bus.iorq && bus.wr && addr[0];
    end

endmodule

`default_nettype wire

// File: logic/work_ram.sv
// CPU work RAM, single port, read and write only on clock-enabled edges
`timescale 1ns/1ps
`default_nettype none
`include "main_settings.svh"

module work_ram import main_pkg::*; (
    input  logic      clk,
    input  logic      cen,
    input  logic      we,
    input  ram_addr_t addr,
    input  byte_t     wdata,
    output byte_t     rdata
);

    localparam int DEPTH = 1 << `MAIN_RAM_AW;

    byte_t mem [DEPTH];   // 2 KB

    // Read returns the old contents on a write edge
    always_ff @(posedge clk) begin
        if (cen) begin
            if (we) begin
                mem[addr] <= wdata;
            end
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// File: logic/security_chip.sv
// Protection device model, two data latches merged through a left shift on read
`timescale 1ns/1ps
`default_nettype none

module security_chip import main_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  cen,
    input  logic  cs,
    input  logic  wr,
    input  logic  rd,
    input  logic  a0,
    input  byte_t wdata,
    output byte_t rdata
);

    byte_t       latest;    // Last byte written
    byte_t       prior;     // The one before it
    logic [2:0]  shift;
    logic [15:0] merged;

    always_ff @(posedge clk) begin
        if (reset) begin
            latest <= '0;
            prior  <= '0;
            shift  <= '0;
        end else if (cen && cs && wr) begin
            if (!a0) begin
                prior  <= latest;   // Data write pushes the pair along
                latest <= wdata;
            end else begin
                shift  <= wdata[2:0];
            end
        end
    end

    // Upper byte of the shifted pair
    assign merged = {latest, prior} << shift;

    // Only drives the bus while read
    assign rdata = (cs && rd) ? merged[15:8] : '0;

endmodule

`default_nettype wire

// File: logic/cabinet_inputs.sv
// Cabinet input multiplexer, puts coin, start, blanking and joysticks on the I/O ports
`timescale 1ns/1ps
`default_nettype none

module cabinet_inputs import main_pkg::*; (
    input  cabinet_t   cab,
    input  logic [1:0] port,
    input  byte_t      psg_data,
    output byte_t      data
);

    // Board wiring swaps up and down
    // In: punch, up, down, left, right. Out: punch, down, up, left, right
    function automatic logic [4:0] joy_order(input logic [4:0] joy);
        return {joy[4], joy[2], joy[3], joy[1:0]};
    endfunction

    always_comb begin
        data = 8'hff;   // Unused lines pulled up
        case (port)
            2'd0: begin
                data = psg_data;            // Sound chip, DIP switches behind it
            end
            2'd1: begin
                data[7]   = cab.coin;
                data[6]   = cab.service;
                data[5]   = cab.vblank;
                data[3:2] = cab.start;
            end
            2'd2: begin
                data[4:0] = joy_order(cab.joy2);  // Player 2
            end
            2'd3: begin
                data[4:0] = joy_order(cab.joy1);  // Player 1
            end
            default: begin
                data = 8'hff;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: logic/psg_ports.sv
// Sound chip register side, address latch, register file and the two I/O ports
`timescale 1ns/1ps
`default_nettype none
`include "main_settings.svh"

module psg_ports import main_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       cen,
    input  logic       addr_wr,
    input  logic       data_wr,
    input  byte_t      wdata,
    input  logic [3:0] dip1,
    input  byte_t      dip2,
    output byte_t      rdata,
    output logic       flip
);

    localparam int REG_AW = $clog2(`PSG_REG_COUNT);

    logic [REG_AW-1:0] reg_sel;                 // Address latch
    byte_t             regs [`PSG_REG_COUNT];
    logic [2:0]        dip_mux;
    byte_t             dip_word;

    //////////////////////////////////////////////////////////////////////
    // Bus writes

    always_ff @(posedge clk) begin
        if (reset) begin
            reg_sel <= '0;
            for (int i = 0; i < `PSG_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (cen) begin
            if (addr_wr) begin
                reg_sel <= wdata[REG_AW-1:0];   // Upper nibble ignored
            end
            if (data_wr) begin
                regs[reg_sel] <= wdata;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // IOA is an output, IOB reads the DIP switches

    assign flip    = regs[`PSG_REG_IOA][0];
    assign dip_mux = regs[`PSG_REG_IOA][3:1];   // Picks one bit of bank 2

    // Bank 1 straight in, bank 2 one bit at a time
    assign dip_word = {dip2[dip_mux], 3'b000, dip1};

    always_comb begin
        if (reg_sel == REG_AW'(`PSG_REG_IOB)) begin
            rdata = dip_word;       // Input port, not the stored value
        end else begin
            rdata = regs[reg_sel];
        end
    end

endmodule

`default_nettype wire

// File: logic/main_board.sv
// Main CPU board top, CPU bus in, ROM and video ports out, read data back to the CPU
`timescale 1ns/1ps
`default_nettype none
`include "main_settings.svh"

module main_board import main_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       cpu_cen,
    input  cpu_bus_t   bus,
    output byte_t      rd_data,
    output logic       rd_valid,
    input  cabinet_t   cab,
    input  logic [3:0] dip1,
    input  byte_t      dip2,
    output logic       rom_cs,
    output rom_addr_t  rom_addr,
    input  byte_t      rom_data,
    output vid_wr_t    vid_wr,
    output logic       flip
);

    addr_t     addr;        // Descrambled
    chip_sel_t sel;
    byte_t     ram_rdata, sec_rdata, psg_rdata, cab_data;
    logic      rd_pend;     // Read taken on the last cpu_cen edge
    logic      rd_from_ram;
    byte_t     rd_hold;     // Non-RAM data sampled with the cycle

    addr_decode addr_decode_inst (.bus(bus), .addr(addr), .sel(sel));

    //////////////////////////////////////////////////////////////////////
    // External ROM and video

    assign rom_cs   = sel.rom && bus.mreq;
    assign rom_addr = addr[`MAIN_ROM_AW-1:0];

    always_comb begin
        vid_wr.valid = cpu_cen && bus.wr && (sel.txt || sel.bgd);  // One clk wide
        vid_wr.bgd   = sel.bgd;
        vid_wr.addr  = addr[`MAIN_VID_AW-1:0];
        vid_wr.data  = bus.wdata;
    end

    //////////////////////////////////////////////////////////////////////
    // On-board devices

    work_ram work_ram_inst (
        .clk(clk), .cen(cpu_cen), .we(sel.ram && bus.wr),
        .addr(addr[`MAIN_RAM_AW-1:0]), .wdata(bus.wdata), .rdata(ram_rdata)
    );

    security_chip security_chip_inst (
        .clk(clk), .reset(reset), .cen(cpu_cen), .cs(sel.sec), .wr(bus.wr),
        .rd(bus.rd), .a0(addr[0]), .wdata(bus.wdata), .rdata(sec_rdata)
    );

    // PSG only drives the data bus during its own read
    cabinet_inputs cabinet_inputs_inst (
        .cab(cab), .port(sel.port),
        .psg_data(sel.psg_rd ? psg_rdata : 8'hff), .data(cab_data)
    );

    psg_ports psg_ports_inst (
        .clk(clk), .reset(reset), .cen(cpu_cen), .addr_wr(sel.psg_addr_wr),
        .data_wr(sel.psg_data_wr), .wdata(bus.wdata), .dip1(dip1), .dip2(dip2),
        .rdata(psg_rdata), .flip(flip)
    );

    //////////////////////////////////////////////////////////////////////
    // Read data, RAM word only exists after the cycle edge

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_pend  <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            rd_pend  <= cpu_cen && bus.rd;
            rd_valid <= rd_pend;
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_cen) begin
            rd_from_ram <= !sel.rom && sel.ram;
            if (sel.rom)        rd_hold <= rom_data;   // Priority order
            else if (sel.io_rd) rd_hold <= cab_data;
            else if (sel.sec)   rd_hold <= sec_rdata;
            else                rd_hold <= '0;         // Open bus reads 0
        end
        if (rd_pend) begin
            rd_data <= rd_from_ram ? ram_rdata : rd_hold;
        end
    end

endmodule

`default_nettype wire

// File: test/main_board_tb.sv
// Testbench that plays the CPU on the main board from a table of bus cycles checked against a model
`timescale 1ns/1ps
`default_nettype none
`include "main_settings.svh"

module main_board_tb import main_pkg::*; ();

    localparam logic [1:0] MEM_RD = 2'd0, MEM_WR = 2'd1, IO_RD = 2'd2, IO_WR = 2'd3;
    localparam addr_t PSG_DATA_PORT = 16'h0000;  // Descrambled bit 0 set
    localparam addr_t PSG_ADDR_PORT = 16'h0001;  // Descrambled bit 0 clear
    localparam addr_t PSG_READ_PORT = 16'h0003;  // Descrambled port 0

    typedef struct packed {
        logic [1:0] kind;       // Bit 1 I/O, bit 0 write
        addr_t      addr;       // Scrambled as the CPU drives it
        byte_t      wdata;
        cabinet_t   cab;
        logic [3:0] dip1;
        byte_t      dip2;
        byte_t      want;       // Expected read data
        logic       flip_want;
    } cycle_t;

    logic clk, reset, cpu_cen, rd_valid, rom_cs, flip, timed_out, rom_want;
    cpu_bus_t bus;
    cabinet_t cab, cur_cab;
    logic [3:0] dip1, cur_dip1, psg_sel, preg;
    byte_t dip2, cur_dip2, rd_data, rom_data, sec_latest, sec_prior;
    byte_t ram_model [2048];
    byte_t psg_regs [`PSG_REG_COUNT];
    logic [2:0] sec_shift;
    rom_addr_t rom_addr;
    vid_wr_t vid_wr, vid_seen;
    addr_t a;
    cycle_t e;
    cycle_t stimulus_q [$];
    addr_t ram_scr [8];
    logic [31:0] r;
    logic [31:0] lfsr = 32'h206b;
    int vid_count = 0;
    int vid_base, vid_want, errors, fails_before, failed_tests;
    string kind_names [4] = '{"mem rd", "mem wr", "io rd", "io wr"};

    main_board main_board_inst (
        .clk(clk), .reset(reset), .cpu_cen(cpu_cen), .bus(bus), .rd_data(rd_data),
        .rd_valid(rd_valid), .cab(cab), .dip1(dip1), .dip2(dip2), .rom_cs(rom_cs),
        .rom_addr(rom_addr), .rom_data(rom_data), .vid_wr(vid_wr), .flip(flip)
    );

    assign rom_data = rom_addr[7:0] ^ {1'b0, rom_addr[14:8]};  // ROM contents model

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cpu_cen = 1'b0;
        forever begin
            @(posedge clk);
            #5 cpu_cen = ~cpu_cen;  // High on every other clk
        end
    end

    // Video pulses counted on the falling edge
    always @(negedge clk) begin
        if (vid_wr.valid) begin
            vid_count = vid_count + 1;
            vid_seen  = vid_wr;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Board model

    function automatic addr_t descramble(input addr_t s);
        return {s[15:10], s[8], s[7], s[6], s[3], ~s[9], ~s[5], ~s[4], ~s[2:0]};
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // Punch, down, up, then left and right
    function automatic byte_t stick_byte(input logic [4:0] joy);
        return {3'b111, joy[4], joy[2], joy[3], joy[1:0]};
    endfunction

    task automatic add_cycle(input logic [1:0] kind, input addr_t scr, input byte_t data);
        addr_t       d;
        byte_t       want;
        logic [15:0] pair;
        d    = descramble(scr);
        want = '0;  // Unmapped reads
        pair = {sec_latest, sec_prior} << sec_shift;
        case (kind)
            MEM_RD: begin
                if (!d[15]) want = d[7:0] ^ {1'b0, d[14:8]};
                else if (d[15:13] == `MAP_RAM && !d[11]) want = ram_model[d[10:0]];
                else if (d[15:13] == `MAP_SEC) want = pair[15:8];
            end
            MEM_WR: begin
                if (d[15:13] == `MAP_RAM && !d[11]) ram_model[d[10:0]] = data;
                else if (d[15:13] == `MAP_SEC && d[0]) sec_shift = data[2:0];
                else if (d[15:13] == `MAP_SEC) begin
                    sec_prior  = sec_latest;
                    sec_latest = data;
                end
            end
            IO_RD: begin
                case (d[1:0])
                    2'd0: want = (psg_sel == 4'(`PSG_REG_IOB)) ?
                        {cur_dip2[psg_regs[`PSG_REG_IOA][3:1]], 3'b000, cur_dip1} :
                        psg_regs[psg_sel];
                    2'd1: want = {cur_cab.coin, cur_cab.service, cur_cab.vblank, 1'b1,
                                  cur_cab.start, 2'b11};
                    2'd2: want = stick_byte(cur_cab.joy2);
                    default: want = stick_byte(cur_cab.joy1);
                endcase
            end
            default: begin
                if (d[0]) psg_regs[psg_sel] = data;
                else psg_sel = data[3:0];
            end
        endcase
        stimulus_q.push_back(cycle_t'{kind: kind, addr: scr, wdata: data, cab: cur_cab,
            dip1: cur_dip1, dip2: cur_dip2, want: want,
            flip_want: psg_regs[`PSG_REG_IOA][0]});
    endtask

    task automatic build_table();
        for (int i = 0; i < 6; i++) begin   // ROM
            r = rand_bits(15);
            add_cycle(MEM_RD, {1'b0, r[14:0]}, 8'h00);
        end
        for (int i = 0; i < 8; i++) begin   // Work RAM fill
            r = rand_bits(19);
            ram_scr[i] = {5'b10000, r[10:0]};
            add_cycle(MEM_WR, ram_scr[i], r[18:11]);
        end
        for (int i = 0; i < 8; i++) add_cycle(MEM_RD, ram_scr[i], 8'h00);
        for (int i = 0; i < 3; i++) begin   // Upper half of the RAM window is open
            r = rand_bits(11);
            add_cycle(MEM_RD, {5'b10001, r[10:0]}, 8'h00);
        end
        for (int i = 0; i < 6; i++) begin   // Text then background
            r = rand_bits(21);
            add_cycle(MEM_WR, {(i < 3) ? `MAP_TXT : `MAP_BGD, r[12:0]}, r[20:13]);
        end
        for (int s = 0; s < 8; s++) begin   // Protection at every shift
            r = rand_bits(16);
            add_cycle(MEM_WR, {3'b111, 12'h000, 1'b1}, r[7:0]);
            add_cycle(MEM_WR, {3'b111, 12'h5a5, 1'b1}, r[15:8]);
            add_cycle(MEM_WR, {3'b111, 12'h000, 1'b0}, {5'h00, s[2:0]});
            add_cycle(MEM_RD, {3'b111, 13'h0000}, 8'h00);
        end
        for (int i = 0; i < 4; i++) begin   // Cabinet ports
            r = rand_bits(15);
            cur_cab = r[14:0];
            for (int p = 1; p < 4; p++) add_cycle(IO_RD, {14'h0000, ~p[1:0]}, 8'h00);
        end
        for (int i = 0; i < 4; i++) begin   // Plain PSG registers
            r = rand_bits(12);
            preg = r[3:0] % 4'd14;
            add_cycle(IO_WR, PSG_ADDR_PORT, {4'h0, preg});
            add_cycle(IO_WR, PSG_DATA_PORT, r[11:4]);
            add_cycle(IO_RD, PSG_READ_PORT, 8'h00);
        end
        for (int s = 0; s < 8; s++) begin   // Flip and DIP bank 2 select
            r = rand_bits(13);
            cur_dip1 = r[3:0];
            cur_dip2 = r[11:4];
            add_cycle(IO_WR, PSG_ADDR_PORT, 8'(`PSG_REG_IOA));
            add_cycle(IO_WR, PSG_DATA_PORT, {4'h0, s[2:0], r[12]});
            add_cycle(IO_WR, PSG_ADDR_PORT, 8'(`PSG_REG_IOB));
            add_cycle(IO_RD, PSG_READ_PORT, 8'h00);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Bus sequencing

    task automatic report_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        errors++;
    endtask

    // Returns just after an edge that took a cycle
    task automatic wait_cen_edge();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!cpu_cen && n < 8);
        if (!cpu_cen) begin
            $display("Timeout: cpu_cen never came high");
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_read();
        int n;
        n = 0;
        while (!rd_valid && n < 8) begin
            @(negedge clk);
            n++;
        end
        if (!rd_valid) begin
            $display("Timeout: no read data came back");
            timed_out = 1'b1;
        end
    endtask

    initial begin
        reset = 1'b1;
        bus = '0;
        cab = '0;
        dip1 = '0;
        dip2 = '0;
        errors = 0;
        failed_tests = 0;
        timed_out = 1'b0;
        cur_cab = '0;
        cur_dip1 = '0;
        cur_dip2 = '0;
        psg_sel = '0;
        sec_latest = '0;
        sec_prior = '0;
        sec_shift = '0;
        for (int i = 0; i < `PSG_REG_COUNT; i++) psg_regs[i] = '0;
        build_table();

        repeat (16) @(posedge clk);
        #5 reset = 1'b0;
        @(negedge clk);
        assert (!rd_valid && !vid_wr.valid && !rom_cs && !flip)
            else report_error("outputs not idle after reset");

        for (int i = 0; i < stimulus_q.size(); i++) begin
            e = stimulus_q[i];
            a = descramble(e.addr);
            fails_before = errors;
            wait_cen_edge();
            if (timed_out) break;
            #5;
            bus = '{mreq: !e.kind[1], iorq: e.kind[1], rd: !e.kind[0], wr: e.kind[0],
                    addr: e.addr, wdata: e.wdata};
            cab  = e.cab;
            dip1 = e.dip1;
            dip2 = e.dip2;
            vid_base = vid_count;
            @(negedge clk);
            rom_want = !e.kind[1] && !a[15];    // ROM select is combinational
            assert (rom_cs == rom_want && (!rom_want || rom_addr == a[14:0]))
                else report_error($sformatf("rom_cs %b rom_addr %h, expected %b %h",
                                            rom_cs, rom_addr, rom_want, a[14:0]));
            wait_cen_edge();
            if (timed_out) break;
            #5 bus = '0;
            if (!e.kind[0]) begin
                wait_read();
                if (timed_out) break;
                assert (rd_data == e.want)
                    else report_error($sformatf("read %h at %h, expected %h",
                                                rd_data, e.addr, e.want));
            end else begin
                @(negedge clk);   // Gives a stray video pulse time to show
            end
            #5;   // Past the pulse counter's falling edge
            vid_want = (e.kind == MEM_WR && (a[15:13] == `MAP_TXT || a[15:13] == `MAP_BGD))
                ? 1 : 0;
            assert ((vid_count - vid_base) == vid_want)
                else report_error($sformatf("%0d video pulses, expected %0d",
                                            vid_count - vid_base, vid_want));
            assert (vid_want == 0 || (vid_seen.bgd == (a[15:13] == `MAP_BGD) &&
                    vid_seen.addr == a[12:0] && vid_seen.data == e.wdata))
                else report_error($sformatf("video write %b %h %h, expected %h %h",
                                            vid_seen.bgd, vid_seen.addr, vid_seen.data,
                                            a[12:0], e.wdata));
            assert (flip == e.flip_want)
                else report_error($sformatf("flip %b, expected %b", flip, e.flip_want));
            if (errors != fails_before) failed_tests++;
            $display("test %0d %s addr %h: %s", i, kind_names[e.kind], e.addr,
                     (errors == fails_before) ? "ok" : "failed");
        end

        $display("%0d tests, %0d failed, %0d errors", stimulus_q.size(), failed_tests,
                 errors);
        if (errors == 0 && !timed_out) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
logic/main_pkg.sv
logic/addr_decode.sv
logic/work_ram.sv
logic/security_chip.sv
logic/cabinet_inputs.sv
logic/psg_ports.sv
logic/main_board.sv
test/main_board_tb.sv

// File: run_sim.sh
#!/bin/sh
verilator --binary --timing --top-module main_board_tb -f verilog.f -o main_board_sim \
    > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/main_board_sim > sim.log 2>&1 \
    || { cat sim.log; echo "Simulation did not run to the end"; exit 1; }
cat sim.log
grep -q "Finished with errors" sim.log \
    && { echo "Simulation failed"; exit 1; } \
    || echo "Simulation passed"
